// File: src/axi_ram_pkg.sv
// Widths fixed for a 4 KiB byte address space of 32-bit words; change them here only
package axi_ram_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	localparam int ID_WIDTH = 4;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int ADDR_WIDTH = 12;

	// Byte address minus the two offset bits of a 32-bit word
	localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;

	// AXI4 burst length field, beats = value + 1
	localparam int LEN_WIDTH = 8;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	// Transaction ID, echoed on B and R
	typedef logic [ID_WIDTH-1:0] id_t;

	// Byte address as seen on AW and AR
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// Word index into the array, reduced modulo the depth in the array itself
	typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

	// One beat on W or R, one word in the array
	typedef logic [DATA_WIDTH-1:0] data_t;

	// One enable per byte lane
	typedef logic [STRB_WIDTH-1:0] strb_t;

	typedef logic [LEN_WIDTH-1:0] len_t;

endpackage

// File: src/ram_port_if.sv
// One write port and one read port on the same array; no arbitration, both may fire in a cycle
`timescale 1ns/100ps

interface ram_port_if;

	import axi_ram_pkg::*;

	// Write port, one full or partial word per cycle
	logic wr_en;
	word_addr_t wr_addr;
	data_t wr_data;
	strb_t wr_strb;

	// Read port, data registered in the array
	logic rd_en;
	word_addr_t rd_addr;
	data_t rd_data;

	modport writer (
		output wr_en,
		output wr_addr,
		output wr_data,
		output wr_strb
	);

	modport reader (
		output rd_en,
		output rd_addr
	);

	modport memory (
		input wr_en,
		input wr_addr,
		input wr_data,
		input wr_strb,
		input rd_en,
		input rd_addr,
		output rd_data
	);

endinterface

// File: src/axi_write_engine.sv
// INCR full-width bursts only, one burst in flight; beats past awlen are accepted but not stored
`timescale 1ns/100ps

module axi_write_engine (
	input logic aclk,
	input logic aresetn,

	// Write address channel
	input axi_ram_pkg::id_t awid,
	input axi_ram_pkg::addr_t awaddr,
	input axi_ram_pkg::len_t awlen,
	input logic awvalid,
	output logic awready,

	// Write data channel
	input axi_ram_pkg::data_t wdata,
	input axi_ram_pkg::strb_t wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	// Write response channel
	output axi_ram_pkg::id_t bid,
	output logic bvalid,
	input logic bready,

	ram_port_if.writer ram
);

	import axi_ram_pkg::*;

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} wr_state_t;

	wr_state_t state;

	id_t id_q;
	word_addr_t word_q;
	len_t beats_left;
	logic overrun;

	logic aw_hs;
	logic w_hs;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;

	//////////////////////////////
	// Channel control
	//////////////////////////////

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= W_IDLE;
		end else begin
			case (state)
				W_IDLE: begin
					if (aw_hs)
						state <= W_DATA;
				end
				W_DATA: begin
					if (w_hs && wlast)
						state <= W_RESP;
				end
				W_RESP: begin
					if (bready)
						state <= W_IDLE;
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// Handshake outputs decode straight from the state register
	assign awready = (state == W_IDLE);
	assign wready = (state == W_DATA);
	assign bvalid = (state == W_RESP);
	assign bid = id_q;

	//////////////////////////////
	// Burst tracking
	//////////////////////////////

	// Count beats against awlen so a burst that runs long cannot spill over
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			beats_left <= '0;
			overrun <= 1'b0;
		end else if (aw_hs) begin
			beats_left <= awlen;
			overrun <= 1'b0;
		end else if (w_hs) begin
			if (beats_left == '0)
				overrun <= 1'b1;
			else
				beats_left <= beats_left - 1'b1;
		end
	end

	// ID and word address carry no reset
	always_ff @(posedge aclk) begin
		if (aw_hs) begin
			id_q <= awid;
			word_q <= awaddr[ADDR_WIDTH-1:2];
		end else if (w_hs) begin
			word_q <= word_q + 1'b1;
		end
	end

	// Accepted beat goes to the array on the same edge
	assign ram.wr_en = w_hs && !overrun;
	assign ram.wr_addr = word_q;
	assign ram.wr_data = wdata;
	assign ram.wr_strb = wstrb;

endmodule

// File: src/axi_read_engine.sv
// INCR full-width bursts only, one burst in flight; first beat two cycles after the AR handshake
`timescale 1ns/100ps

module axi_read_engine (
	input logic aclk,
	input logic aresetn,

	// Read address channel
	input axi_ram_pkg::id_t arid,
	input axi_ram_pkg::addr_t araddr,
	input axi_ram_pkg::len_t arlen,
	input logic arvalid,
	output logic arready,

	// Read data channel, rdata comes from the array
	output axi_ram_pkg::id_t rid,
	output logic rlast,
	output logic rvalid,
	input logic rready,

	ram_port_if.reader ram
);

	import axi_ram_pkg::*;

	typedef enum logic [1:0] {
		R_IDLE,
		R_FETCH,
		R_DATA
	} rd_state_t;

	rd_state_t state;

	id_t id_q;
	word_addr_t word_q;
	len_t beats_left;

	logic ar_hs;
	logic r_hs;
	logic fetch;

	assign ar_hs = arvalid && arready;
	assign r_hs = rvalid && rready;

	//////////////////////////////
	// Channel control
	//////////////////////////////

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= R_IDLE;
		end else begin
			case (state)
				R_IDLE: begin
					if (ar_hs)
						state <= R_FETCH;
				end
				// First word is in flight from the array
				R_FETCH: begin
					state <= R_DATA;
				end
				R_DATA: begin
					if (r_hs && rlast)
						state <= R_IDLE;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	assign arready = (state == R_IDLE);

	// Data is valid from the cycle after the first fetch until the last beat is taken
	assign rvalid = (state == R_DATA);
	assign rid = id_q;

	//////////////////////////////
	// Fetch and beat counting
	//////////////////////////////

	// Next word is fetched only when the current one is consumed,
	// so rdata holds while rready is low
	assign fetch = (state == R_FETCH) || (r_hs && !rlast);

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			beats_left <= '0;
		else if (ar_hs)
			beats_left <= arlen;
		else if (r_hs)
			beats_left <= beats_left - 1'b1;
	end

	// Counter reaches zero on the beat whose number equals arlen
	assign rlast = rvalid && (beats_left == '0);

	// Payload registers, no reset
	always_ff @(posedge aclk) begin
		if (ar_hs) begin
			id_q <= arid;
			word_q <= araddr[ADDR_WIDTH-1:2];
		end else if (fetch) begin
			word_q <= word_q + 1'b1;
		end
	end

	assign ram.rd_en = fetch;
	assign ram.rd_addr = word_q;

endmodule

// File: src/byte_ram.sv
// MEM_DEPTH must be a power of two from 2 to 1024; contents are undefined until written
`timescale 1ns/100ps

module byte_ram #(
	parameter int unsigned MEM_DEPTH = 1024
) (
	input logic aclk,
	ram_port_if.memory ram
);

	import axi_ram_pkg::*;

	localparam int IDX_WIDTH = $clog2(MEM_DEPTH);

	data_t mem [MEM_DEPTH];

	logic [IDX_WIDTH-1:0] wr_idx;
	logic [IDX_WIDTH-1:0] rd_idx;

	// Word index wraps at the array depth
	assign wr_idx = ram.wr_addr[IDX_WIDTH-1:0];
	assign rd_idx = ram.rd_addr[IDX_WIDTH-1:0];

	//////////////////////////////
	// Byte-lane writes
	//////////////////////////////

	always_ff @(posedge aclk) begin
		for (int b = 0; b < STRB_WIDTH; b++) begin
			if (ram.wr_en && ram.wr_strb[b])
				mem[wr_idx][8*b +: 8] <= ram.wr_data[8*b +: 8];
		end
	end

	//////////////////////////////
	// Registered read
	//////////////////////////////

	// Same-word collision returns the old word
	always_ff @(posedge aclk) begin
		if (ram.rd_en)
			ram.rd_data <= mem[rd_idx];
	end

endmodule

// File: src/axi_ram.sv
// AXI4 RAM slave, INCR full-width bursts, one write and one read burst in flight, responses OKAY
`timescale 1ns/100ps

module axi_ram #(
	parameter int unsigned MEM_DEPTH = 1024
) (
	input logic aclk,
	input logic aresetn,

	// Write address channel
	input axi_ram_pkg::id_t awid,
	input axi_ram_pkg::addr_t awaddr,
	input axi_ram_pkg::len_t awlen,
	input logic awvalid,
	output logic awready,

	// Write data channel
	input axi_ram_pkg::data_t wdata,
	input axi_ram_pkg::strb_t wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	// Write response channel
	output axi_ram_pkg::id_t bid,
	output logic bvalid,
	input logic bready,

	// Read address channel
	input axi_ram_pkg::id_t arid,
	input axi_ram_pkg::addr_t araddr,
	input axi_ram_pkg::len_t arlen,
	input logic arvalid,
	output logic arready,

	// Read data channel
	output axi_ram_pkg::id_t rid,
	output axi_ram_pkg::data_t rdata,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	ram_port_if ram_bus ();

	//////////////////////////////
	// Write stage
	//////////////////////////////

	axi_write_engine write_engine_i (
		.aclk (aclk),
		.aresetn (aresetn),
		.awid (awid),
		.awaddr (awaddr),
		.awlen (awlen),
		.awvalid (awvalid),
		.awready (awready),
		.wdata (wdata),
		.wstrb (wstrb),
		.wlast (wlast),
		.wvalid (wvalid),
		.wready (wready),
		.bid (bid),
		.bvalid (bvalid),
		.bready (bready),
		.ram (ram_bus.writer)
	);

	//////////////////////////////
	// Read stage
	//////////////////////////////

	axi_read_engine read_engine_i (
		.aclk (aclk),
		.aresetn (aresetn),
		.arid (arid),
		.araddr (araddr),
		.arlen (arlen),
		.arvalid (arvalid),
		.arready (arready),
		.rid (rid),
		.rlast (rlast),
		.rvalid (rvalid),
		.rready (rready),
		.ram (ram_bus.reader)
	);

	// Read data leaves the array register directly
	assign rdata = ram_bus.rd_data;

	//////////////////////////////
	// Memory array
	//////////////////////////////

	byte_ram #(
		.MEM_DEPTH (MEM_DEPTH)
	) byte_ram_i (
		.aclk (aclk),
		.ram (ram_bus.memory)
	);

endmodule

// File: tests/axi_ram_sva.sv
// Checks the top-level AXI ports only; assertions are off while aresetn is low
`timescale 1ns/100ps

module axi_ram_sva (
	input logic aclk,
	input logic aresetn,
	input logic awvalid,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input axi_ram_pkg::id_t rid,
	input axi_ram_pkg::data_t rdata,
	input logic rlast,
	input logic rvalid,
	input logic rready
);

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	//////////////////////////////
	// Channel stability
	//////////////////////////////

	// Stalled read beat keeps its payload
	r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rid))
		else begin
			fail_count++;
			$error("R beat changed while rready was low");
		end

	b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	// One write burst at a time
	aw_block: assert property (@(posedge aclk) disable iff (!aresetn)
		awvalid && awready |=> (!awready until (bvalid && bready)))
		else begin
			fail_count++;
			$error("awready rose before the B handshake");
		end

	w_after_reset: assert property (@(posedge aclk) $rose(aresetn) |-> !wready)
		else begin
			fail_count++;
			$error("wready high right after reset");
		end

endmodule

bind axi_ram axi_ram_sva sva_i (
	.aclk (aclk),
	.aresetn (aresetn),
	.awvalid (awvalid),
	.awready (awready),
	.wready (wready),
	.bvalid (bvalid),
	.bready (bready),
	.rid (rid),
	.rdata (rdata),
	.rlast (rlast),
	.rvalid (rvalid),
	.rready (rready)
);

// File: tests/axi_ram_tb.sv
// Reads tests/axi_ram_stim.txt relative to the project root; bursts in one P command must not share words
`timescale 1ns/100ps

module axi_ram_tb;

	import axi_ram_pkg::*;

	localparam int TIMEOUT = 200;

	logic aclk = 1'b0;
	logic aresetn;
	id_t awid;
	addr_t awaddr;
	len_t awlen;
	logic awvalid;
	logic awready;
	data_t wdata;
	strb_t wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	id_t bid;
	logic bvalid;
	logic bready;
	id_t arid;
	addr_t araddr;
	len_t arlen;
	logic arvalid;
	logic arready;
	id_t rid;
	data_t rdata;
	logic rlast;
	logic rvalid;
	logic rready;

	logic [31:0] rng = 32'd9595;
	int n_checks = 0;
	int n_cmds = 0;

	// Current write command and current read command from the stim file
	id_t w_id;
	addr_t w_addr;
	len_t w_len;
	data_t w_data [256];
	strb_t w_strb [256];
	id_t r_id;
	addr_t r_addr;
	len_t r_len;
	data_t r_exp [256];

	axi_ram #(.MEM_DEPTH(1024)) axi_ram_i (.*);

	always #20 aclk = ~aclk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	// Failures of the protocol assertions bound to the DUT
	always @(axi_ram_i.sva_i.fail_count) begin
		if (axi_ram_i.sva_i.fail_count != 0)
			abort_run("A protocol assertion on the DUT ports failed");
	end

	task automatic check_data(input string name, input data_t exp, input data_t act);
		n_checks++;
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_id(input string name, input id_t exp, input id_t act);
		n_checks++;
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// High about three cycles in four
	function automatic logic random_ready();
		rng = xorshift32(rng);
		return rng[1:0] != 2'b00;
	endfunction

	function automatic logic slave_ready(input string chan);
		if (chan == "AW")
			return awready;
		else if (chan == "W")
			return wready;
		return arready;
	endfunction

	// Called at a drive point with valid already high, returns at the drive point after the handshake
	task automatic wait_chan(input string chan);
		int cycles;
		cycles = 0;
		@(negedge aclk);
		while (!slave_ready(chan)) begin
			cycles++;
			if (cycles >= TIMEOUT)
				abort_run($sformatf("Timeout: no %s handshake within %0d cycles", chan, TIMEOUT));
			@(negedge aclk);
		end
		@(posedge aclk);
		#2;
	endtask

	task automatic run_write();
		int cycles;
		awid = w_id;
		awaddr = w_addr;
		awlen = w_len;
		awvalid = 1'b1;
		wait_chan("AW");
		awvalid = 1'b0;
		for (int i = 0; i <= w_len; i++) begin
			wdata = w_data[i];
			wstrb = w_strb[i];
			wlast = (i == w_len);
			wvalid = 1'b1;
			wait_chan("W");
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		cycles = 0;
		bready = random_ready();
		@(negedge aclk);
		while (!(bvalid && bready)) begin
			// No new write address while the response is pending
			check_flag("awready", 1'b0, awready);
			cycles++;
			if (cycles >= TIMEOUT)
				abort_run("Timeout: no B handshake within 200 cycles");
			@(posedge aclk);
			#2;
			bready = random_ready();
			@(negedge aclk);
		end
		check_id("bid", w_id, bid);
		@(posedge aclk);
		#2;
		bready = 1'b0;
		@(negedge aclk);
		check_flag("awready", 1'b1, awready);
		@(posedge aclk);
		#2;
	endtask

	task automatic run_read();
		int beat;
		int cycles;
		arid = r_id;
		araddr = r_addr;
		arlen = r_len;
		arvalid = 1'b1;
		wait_chan("AR");
		arvalid = 1'b0;
		beat = 0;
		cycles = 0;
		while (beat <= r_len) begin
			rready = random_ready();
			@(negedge aclk);
			if (rvalid && rready) begin
				check_data("rdata", r_exp[beat], rdata);
				check_id("rid", r_id, rid);
				check_flag("rlast", beat == r_len, rlast);
				beat++;
				cycles = 0;
			end else begin
				cycles++;
				if (cycles >= TIMEOUT)
					abort_run("Timeout: no R handshake within 200 cycles");
			end
			@(posedge aclk);
			#2;
		end
		rready = 1'b0;
		// Burst ends after exactly arlen plus one beats
		@(negedge aclk);
		check_flag("rvalid", 1'b0, rvalid);
		@(posedge aclk);
		#2;
	endtask

	task automatic load_write(input int fd);
		int n;
		n = $fscanf(fd, "%h %h %h", w_id, w_addr, w_len);
		if (n != 3)
			abort_run("Stim file has a bad W header");
		for (int i = 0; i <= w_len; i++) begin
			n = $fscanf(fd, "%h %h", w_data[i], w_strb[i]);
			if (n != 2)
				abort_run("Stim file is missing a W beat");
		end
	endtask

	task automatic load_read(input int fd);
		int n;
		n = $fscanf(fd, "%h %h %h", r_id, r_addr, r_len);
		if (n != 3)
			abort_run("Stim file has a bad R header");
		for (int i = 0; i <= r_len; i++) begin
			n = $fscanf(fd, "%h", r_exp[i]);
			if (n != 1)
				abort_run("Stim file is missing an expected R word");
		end
	endtask

	initial begin
		int fd;
		logic [8*8-1:0] kind;
		logic [8*200-1:0] line;
		aresetn = 1'b0;
		awid = '0;
		awaddr = '0;
		awlen = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arid = '0;
		araddr = '0;
		arlen = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge aclk);
		#2;
		aresetn = 1'b1;
		@(negedge aclk);
		check_flag("awready", 1'b1, awready);
		check_flag("arready", 1'b1, arready);
		check_flag("wready", 1'b0, wready);
		check_flag("bvalid", 1'b0, bvalid);
		check_flag("rvalid", 1'b0, rvalid);
		@(posedge aclk);
		#2;
		fd = $fopen("tests/axi_ram_stim.txt", "r");
		if (fd == 0)
			abort_run("Cannot open tests/axi_ram_stim.txt");
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "#") begin
				void'($fgets(line, fd));
			end else if (kind == "W") begin
				load_write(fd);
				run_write();
				n_cmds++;
			end else if (kind == "R") begin
				load_read(fd);
				run_read();
				n_cmds++;
			end else if (kind == "P") begin
				void'($fscanf(fd, "%s", kind));
				if (kind != "W")
					abort_run("Stim file has a P command without its W record");
				load_write(fd);
				void'($fscanf(fd, "%s", kind));
				if (kind != "R")
					abort_run("Stim file has a P command without its R record");
				load_read(fd);
				fork
					run_write();
					run_read();
				join
				n_cmds++;
			end else begin
				abort_run($sformatf("Stim file has an unknown command %0s", kind));
			end
		end
		$fclose(fd);
		if (n_cmds > 0 && n_checks > 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("No commands were run from the stim file");
		end
	end

endmodule

// File: tests/axi_ram_stim.txt
# W id addr len then one data and strobe pair per beat (all hex)
# R id addr len then the expected word per beat; P runs the next W and R side by side
W 1 000 0
11111111 f
W 2 010 3
a0a0a001 f a0a0a002 f a0a0a003 f a0a0a004 f
W 3 100 f
c0de0000 f c0de0001 f c0de0002 f c0de0003 f
c0de0004 f c0de0005 f c0de0006 f c0de0007 f
c0de0008 f c0de0009 f c0de000a f c0de000b f
c0de000c f c0de000d f c0de000e f c0de000f f
R 4 000 0
11111111
R 5 010 3
a0a0a001 a0a0a002 a0a0a003 a0a0a004
R 6 100 f
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f
# Partial strobes over the burst at 010
W 7 010 3
00000055 1 00006600 2 77000000 8 bbccddee 5
R 8 010 3
a0a0a055 a0a06602 77a0a003 a0cca0ee
W 9 000 0
12345678 6
R a 000 0
11345611
# Write to 200 while reading back 100
P
W b 200 7
d0000000 f d0000001 f d0000002 f d0000003 f
d0000004 f d0000005 f d0000006 f d0000007 f
R c 100 f
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f
R d 200 7
d0000000 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
R e 120 3
c0de0008 c0de0009 c0de000a c0de000b

// File: filelist.f
src/axi_ram_pkg.sv
src/ram_port_if.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/byte_ram.sv
src/axi_ram.sv
tests/axi_ram_sva.sv
tests/axi_ram_tb.sv

// File: Bender.yml
package:
  name: axi_ram

sources:
  - files:
      - src/axi_ram_pkg.sv
      - src/ram_port_if.sv
      - src/axi_write_engine.sv
      - src/axi_read_engine.sv
      - src/byte_ram.sv
      - src/axi_ram.sv
  - target: test
    files:
      - tests/axi_ram_sva.sv
      - tests/axi_ram_tb.sv
